//--- project.f
verilog/bus_pkg.sv
verilog/bus_arbiter.sv
verilog/tx_fifo.sv
verilog/uart_tx.sv
verilog/bus_tx_system.sv
tests/bus_tx_props.sv
tests/tb_bus_tx_system.sv

//--- Makefile
# Verilator build of the bus transmit testbench

BIN := obj_dir/Vtb_bus_tx_system

all: $(BIN)

$(BIN): project.f $(wildcard verilog/*.sv) $(wildcard tests/*.sv)
	verilator --binary --timing --assert -j 0 --top-module tb_bus_tx_system -f project.f

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

.PHONY: all run clean

//--- tests/tb_bus_tx_system.sv
`timescale 1ns/10ps

module tb_bus_tx_system;
    import bus_pkg::*;

    localparam int     total_bytes = 170;  // upper bound, all tests together
    localparam longint watchdog_ns = 2 * longint'(total_bytes) * 10 * clks_per_bit * 20
                                     + 100_000;

    logic                   clk50MHz;
    logic                   rst_n;
    logic [num_masters-1:0] req;
    bus_word_t              words [num_masters];
    logic [num_masters-1:0] ack;
    logic                   tx;
    logic                   tx_busy;

    bus_word_t   pending [num_masters][$];  // words each master still has to send
    logic [7:0]  exp_bytes [$];
    string       test_name = "none";
    logic [31:0] lcg_state = 32'hdce6_1c87;
    int          last_grant = num_masters - 1;  // model of the rotating pointer
    bit          check_rotation = 1'b0;
    int          acked = 0;
    int          completed = 0;
    int          peak_outstanding = 0;
    int          rx_count = 0;
    bit          busy_prev = 1'b0;
    bit          run_done = 1'b0;
    bit          fail_reported = 1'b0;

    bus_tx_system i_bus_tx_system (
        .clk50MHz (clk50MHz),
        .rst_n    (rst_n),
        .req      (req),
        .words    (words),
        .ack      (ack),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    initial begin
        clk50MHz = 1'b0;
        forever #10 clk50MHz = ~clk50MHz;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
        fail_reported = 1'b1;
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    final begin
        if (!run_done && !fail_reported) begin
            $display("*** FAILED ***");
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic bus_word_t make_word(input int count, input bus_data_t data);
        bus_word_t w;
        w.ctrl.byte_count = byte_count_t'(count);
        w.ctrl.reserved   = 5'b10101;  // ignored by the DUT
        w.data            = data;
        return w;
    endfunction

    task automatic check_value(input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %0h actual %0h", test_name, expected, actual);
            fail_reported = 1'b1;
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s in test %s", what, test_name);
        fail_reported = 1'b1;
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    // masters present their next word 2 ns after the edge
    initial begin : master_driver
        req = '0;
        for (int i = 0; i < num_masters; i++) begin
            words[i] = '0;
        end
        forever begin
            @(posedge clk50MHz);
            #2;
            for (int i = 0; i < num_masters; i++) begin
                req[i] = (pending[i].size() != 0);
                if (pending[i].size() != 0) begin
                    words[i] = pending[i][0];
                end
            end
        end
    end

    // ack seen mid cycle is taken at the next rising edge
    initial begin : ack_monitor
        bus_word_t w;
        forever begin
            @(negedge clk50MHz);
            for (int i = 0; i < num_masters; i++) begin
                if (rst_n && ack[i]) begin
                    if (pending[i].size() == 0) begin
                        report_failure("ack given to a master with no word");
                    end else begin
                        w = pending[i].pop_front();
                        if (check_rotation) begin
                            check_value(64'((last_grant + 1) % num_masters), 64'(i));
                        end
                        last_grant = i;
                        for (int b = 0; b < int'(w.ctrl.byte_count); b++) begin
                            exp_bytes.push_back(8'(w.data >> (8 * b)));
                        end
                        acked++;
                    end
                end
            end
            if (busy_prev && !tx_busy) begin
                completed++;  // one word fully sent
            end
            busy_prev = tx_busy;
            if (acked - completed > peak_outstanding) begin
                peak_outstanding = acked - completed;
            end
            if (acked - completed > fifo_depth + 1) begin
                report_failure("more words acknowledged than buffer and serializer can hold");
            end
        end
    end

    initial begin : uart_receiver
        logic [7:0] rx_byte;
        rx_byte = '0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge tx);
            repeat (clks_per_bit / 2) @(negedge clk50MHz);
            if (tx !== 1'b0) begin
                report_failure("start bit on the UART line shorter than half a bit");
            end else begin
                for (int b = 0; b < 8; b++) begin
                    repeat (clks_per_bit) @(negedge clk50MHz);
                    rx_byte = {tx, rx_byte[7:1]};  // lsb first
                end
                repeat (clks_per_bit) @(negedge clk50MHz);
                if (tx !== 1'b1) begin
                    report_failure("stop bit missing on the UART line");
                end else if (exp_bytes.size() == 0) begin
                    report_failure("UART byte arrived with no word acknowledged for it");
                end else begin
                    check_value(64'(exp_bytes.pop_front()), 64'(rx_byte));
                    rx_count++;
                end
            end
        end
    end

    task automatic wait_drained();
        bit busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk50MHz);
            busy = tx_busy || (exp_bytes.size() != 0);
            for (int i = 0; i < num_masters; i++) begin
                if (pending[i].size() != 0) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    task automatic test_reset();
        test_name = "reset";
        check_value(64'(0), 64'(ack));
        check_value(64'(1), 64'(tx));
        check_value(64'(0), 64'(tx_busy));
    endtask

    task automatic test_single_word();
        test_name = "single_word";
        @(posedge clk50MHz);
        pending[2].push_back(make_word(4, 32'ha5c3_0f81));
        wait_drained();
    endtask

    task automatic test_byte_count();
        int start_count;
        test_name = "byte_count";
        @(posedge clk50MHz);
        for (int n = 1; n <= 3; n++) begin
            pending[1].push_back(make_word(n, next_random()));
        end
        for (int n = 1; n <= 3; n++) begin
            start_count = rx_count;
            while (!tx_busy) begin
                @(negedge clk50MHz);
            end
            while (tx_busy) begin
                @(negedge clk50MHz);
            end
            check_value(64'(n), 64'(rx_count - start_count));  // bytes of this word only
        end
        wait_drained();
    endtask

    task automatic test_round_robin();
        test_name = "round_robin";
        @(posedge clk50MHz);
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < num_masters; i++) begin
                pending[i].push_back(make_word(4, next_random()));
            end
        end
        check_rotation = 1'b1;
        wait_drained();
        check_rotation = 1'b0;
    endtask

    task automatic test_back_pressure();
        test_name        = "back_pressure";
        peak_outstanding = 0;
        @(posedge clk50MHz);
        for (int k = 0; k < 12; k++) begin
            pending[3].push_back(make_word(4, next_random()));
        end
        wait_drained();
        check_value(64'(fifo_depth + 1), 64'(peak_outstanding));
    endtask

    task automatic test_random();
        logic [31:0] r;
        test_name = "random";
        for (int k = 0; k < 16; k++) begin
            @(posedge clk50MHz);
            r = next_random();
            pending[int'(r[31:30])].push_back(make_word(int'(r[29:28]) + 1, next_random()));
            repeat (int'(r[27:24])) @(posedge clk50MHz);  // random gap
        end
        wait_drained();
    endtask

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk50MHz);
        #2;
        rst_n = 1'b1;
        @(negedge clk50MHz);
        test_reset();
        test_single_word();
        test_byte_count();
        test_round_robin();
        test_back_pressure();
        test_random();
        run_done = 1'b1;
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- tests/bus_tx_props.sv
`timescale 1ns/10ps

module bus_tx_props (
    input logic                            clk50MHz,
    input logic                            rst_n,
    input logic [bus_pkg::num_masters-1:0] req,
    input logic [bus_pkg::num_masters-1:0] ack,
    input bus_pkg::credit_t                credits
);
    import bus_pkg::*;

    ack_onehot: assert property (@(posedge clk50MHz) disable iff (!rst_n)
        $onehot0(ack))
        else $error("ack is set for more than one master");

    // master holds req until it has seen its ack
    ack_to_requester: assert property (@(posedge clk50MHz) disable iff (!rst_n)
        (ack & ~req) == '0)
        else $error("ack given to a master that is not requesting");

    credits_bounded: assert property (@(posedge clk50MHz) disable iff (!rst_n)
        credits <= credit_t'(fifo_depth))
        else $error("credit count above the buffer depth");

    no_ack_without_credit: assert property (@(posedge clk50MHz) disable iff (!rst_n)
        (ack != '0) |-> (credits != '0))
        else $error("ack given with no credit left");

endmodule

bind bus_arbiter bus_tx_props i_props (
    .clk50MHz (clk50MHz),
    .rst_n    (rst_n),
    .req      (req),
    .ack      (ack),
    .credits  (credits)
);

//--- verilog/bus_tx_system.sv
`timescale 1ns/10ps

module bus_tx_system (
    input  logic                            clk50MHz,
    input  logic                            rst_n,
    input  logic [bus_pkg::num_masters-1:0] req,
    input  bus_pkg::bus_word_t              words [bus_pkg::num_masters],
    output logic [bus_pkg::num_masters-1:0] ack,
    output logic                            tx,
    output logic                            tx_busy
);
    import bus_pkg::*;

    logic      bus_valid;
    bus_word_t bus_word;
    logic      credit_return;
    logic      fifo_valid;
    bus_word_t fifo_word;
    logic      fifo_pop;

    bus_arbiter i_arbiter (
        .clk50MHz      (clk50MHz),
        .rst_n         (rst_n),
        .req           (req),
        .words         (words),
        .ack           (ack),
        .bus_valid     (bus_valid),
        .bus_word      (bus_word),
        .credit_return (credit_return)
    );

    tx_fifo i_fifo (
        .clk50MHz      (clk50MHz),
        .rst_n         (rst_n),
        .bus_valid     (bus_valid),
        .bus_word      (bus_word),
        .fifo_valid    (fifo_valid),
        .fifo_word     (fifo_word),
        .fifo_pop      (fifo_pop),
        .credit_return (credit_return)
    );

    uart_tx i_uart (
        .clk50MHz   (clk50MHz),
        .rst_n      (rst_n),
        .fifo_valid (fifo_valid),
        .fifo_word  (fifo_word),
        .fifo_pop   (fifo_pop),
        .tx         (tx),
        .tx_busy    (tx_busy)
    );

endmodule

//--- verilog/uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
    input  logic               clk50MHz,
    input  logic               rst_n,
    input  logic               fifo_valid,
    input  bus_pkg::bus_word_t fifo_word,
    output logic               fifo_pop,
    output logic               tx,
    output logic               tx_busy
);
    import bus_pkg::*;

    tx_state_t   state;
    baud_cnt_t   baud_cnt;
    bit_idx_t    bit_cnt;
    byte_count_t bytes_left;
    bus_data_t   shreg;       // low byte goes out first
    logic        baud_done;

    assign baud_done = (baud_cnt == baud_cnt_t'(clks_per_bit - 1));
    assign tx_busy   = (state != idle);

    // bit timing
    always_ff @(posedge clk50MHz or negedge rst_n) begin
        if (!rst_n) begin
            baud_cnt <= '0;
        end else if (state == idle || baud_done) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + baud_cnt_t'(1);
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (state == idle && fifo_valid) begin
            shreg <= fifo_word.data;
        end else if (state == data && baud_done) begin
            shreg <= shreg >> 1;  // next byte ends up in the low bits
        end
    end

    always_ff @(posedge clk50MHz or negedge rst_n) begin
        if (!rst_n) begin
            state      <= idle;
            tx         <= 1'b1;
            fifo_pop   <= 1'b0;
            bit_cnt    <= '0;
            bytes_left <= '0;
        end else begin
            fifo_pop <= 1'b0;
            case (state)
                idle: begin
                    if (fifo_valid) begin
                        fifo_pop   <= 1'b1;
                        bytes_left <= fifo_word.ctrl.byte_count;
                        tx         <= 1'b0;  // start bit
                        state      <= start;
                    end
                end
                start: begin
                    if (baud_done) begin
                        bit_cnt <= '0;
                        tx      <= shreg[0];
                        state   <= data;
                    end
                end
                data: begin
                    if (baud_done) begin
                        if (bit_cnt == bit_idx_t'(7)) begin
                            tx    <= 1'b1;  // stop bit
                            state <= stop;
                        end else begin
                            bit_cnt <= bit_cnt + bit_idx_t'(1);
                            tx      <= shreg[1];
                        end
                    end
                end
                stop: begin
                    if (baud_done) begin
                        if (bytes_left <= byte_count_t'(1)) begin
                            state <= idle;
                        end else begin
                            bytes_left <= bytes_left - byte_count_t'(1);
                            tx         <= 1'b0;
                            state      <= start;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

//--- verilog/tx_fifo.sv
`timescale 1ns/10ps

module tx_fifo (
    input  logic               clk50MHz,
    input  logic               rst_n,
    input  logic               bus_valid,
    input  bus_pkg::bus_word_t bus_word,
    output logic               fifo_valid,
    output bus_pkg::bus_word_t fifo_word,
    input  logic               fifo_pop,
    output logic               credit_return
);
    import bus_pkg::*;

    bus_word_t mem [fifo_depth];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    credit_t   count;
    logic      push;
    logic      pop;

    // arbiter credits keep a slot free for every push
    assign push = bus_valid;
    assign pop  = fifo_pop && (count != '0);

    assign fifo_valid = (count != '0);
    assign fifo_word  = mem[rd_ptr];

    always_ff @(posedge clk50MHz) begin
        if (push) begin
            mem[wr_ptr] <= bus_word;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk50MHz or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + fifo_ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + fifo_ptr_t'(1);
            end
        end
    end

    always_ff @(posedge clk50MHz or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + credit_t'(1);
                2'b01:   count <= count - credit_t'(1);
                default: count <= count;
            endcase
        end
    end

    // one credit back per word taken
    always_ff @(posedge clk50MHz or negedge rst_n) begin
        if (!rst_n) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;
        end
    end

endmodule

//--- verilog/bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter (
    input  logic                            clk50MHz,
    input  logic                            rst_n,
    input  logic [bus_pkg::num_masters-1:0] req,
    input  bus_pkg::bus_word_t              words [bus_pkg::num_masters],
    output logic [bus_pkg::num_masters-1:0] ack,
    output logic                            bus_valid,
    output bus_pkg::bus_word_t              bus_word,
    input  logic                            credit_return
);
    import bus_pkg::*;

    master_id_t               last_grant;  // rotating priority pointer
    master_id_t               ack_id;      // master holding ack this cycle
    master_id_t               pick;
    logic                     found;
    logic [num_masters-1:0]   eligible;
    credit_t                  credits;
    credit_t                  avail;
    logic                     can_grant;
    logic                     ack_any;

    assign ack_any = (ack != '0);

    // a master seeing ack this cycle still shows its old word
    assign eligible = req & ~ack;

    // the ack in flight already owns one credit
    assign avail     = credits - credit_t'(ack_any);
    assign can_grant = found && (avail != '0);

    // first requester after the last grant
    always_comb begin
        master_id_t idx;
        found = 1'b0;
        pick  = last_grant;
        for (int k = 1; k <= num_masters; k++) begin
            idx = master_id_t'(int'(last_grant) + k);
            if (!found && eligible[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    always_ff @(posedge clk50MHz or negedge rst_n) begin
        if (!rst_n) begin
            ack        <= '0;
            ack_id     <= '0;
            last_grant <= master_id_t'(num_masters - 1);  // search starts at 0
        end else begin
            ack <= '0;
            if (can_grant) begin
                ack[pick]  <= 1'b1;
                ack_id     <= pick;
                last_grant <= pick;
            end
        end
    end

    // bus word follows the ack by one cycle
    always_ff @(posedge clk50MHz or negedge rst_n) begin
        if (!rst_n) begin
            bus_valid <= 1'b0;
        end else begin
            bus_valid <= ack_any;
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (ack_any) begin
            bus_word <= words[ack_id];  // master still holds it here
        end
    end

    // credit count, one per free buffer slot
    always_ff @(posedge clk50MHz or negedge rst_n) begin
        if (!rst_n) begin
            credits <= credit_t'(fifo_depth);
        end else begin
            case ({ack_any, credit_return})
                2'b10:   credits <= credits - credit_t'(1);
                2'b01:   credits <= credits + credit_t'(1);
                default: credits <= credits;  // none, or grant and return together
            endcase
        end
    end

endmodule

//--- verilog/bus_pkg.sv
package bus_pkg;

    localparam int num_masters  = 4;
    localparam int fifo_depth   = 8;    // also the credit count after reset
    localparam int clks_per_bit = 50;   // 50 MHz / 1 Mbaud

    typedef logic [$clog2(num_masters)-1:0]  master_id_t;
    typedef logic [31:0]                     bus_data_t;
    typedef logic [2:0]                      byte_count_t;  // 1 to 4 bytes
    typedef logic [3:0]                      credit_t;      // 0 to fifo_depth
    typedef logic [$clog2(fifo_depth)-1:0]   fifo_ptr_t;
    typedef logic [$clog2(clks_per_bit)-1:0] baud_cnt_t;
    typedef logic [2:0]                      bit_idx_t;     // bit within a byte

    // control word, one byte wide
    typedef struct packed {
        byte_count_t byte_count;
        logic [4:0]  reserved;
    } bus_ctrl_t;

    typedef struct packed {
        bus_ctrl_t ctrl;
        bus_data_t data;
    } bus_word_t;

    typedef enum logic [1:0] {
        idle,
        start,
        data,
        stop
    } tx_state_t;

endpackage
